//--- logic/rv_isa_pkg.sv
// RV32I subset only: no JALR, LUI, AUIPC, CSR, sub-word access or misaligned access
`default_nettype none

package rv_isa_pkg;

  localparam int xlen      = 32;  // Data and address width
  localparam int reg_idx_w = 5;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [31:0]          inst_t;
  typedef logic [2:0]           funct3_t;
  typedef logic [6:0]           funct7_t;

  // Major opcodes kept by the core, bits 6:0
  typedef enum logic [6:0] {
    op_r      = 7'b0110011,
    op_imm    = 7'b0010011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_t;

  // ##################################################
  // Field positions
  localparam int rd_lsb     = 7;
  localparam int funct3_lsb = 12;
  localparam int rs1_lsb    = 15;
  localparam int rs2_lsb    = 20;
  localparam int funct7_lsb = 25;

  // ##################################################
  // Function codes
  localparam funct3_t f3_add  = 3'b000;  // ADD, SUB, ADDI
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;
  localparam funct3_t f3_word = 3'b010;  // LW and SW

  // Branch conditions
  localparam funct3_t f3_beq = 3'b000;
  localparam funct3_t f3_bne = 3'b001;

  localparam funct7_t f7_base = 7'b0000000;
  localparam funct7_t f7_sub  = 7'b0100000;  // SUB only

endpackage

`default_nettype wire

//--- logic/rv_pipe_pkg.sv
// Codes for the five-stage core only; forwarding codes assume operands are picked in decode
`default_nettype none

package rv_pipe_pkg;

  // ALU operations
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll
  } alu_op_t;

  // Where a decode-stage operand is taken from
  typedef enum logic [2:0] {
    fwd_rf,         // Register file
    fwd_ex_alu,     // Execute ALU result
    fwd_mem_rdata,  // Load data in the memory stage
    fwd_mem_alu,    // Memory-stage ALU result
    fwd_wb          // Write-back value
  } fwd_sel_t;

  // ##################################################
  // Fetch
  localparam rv_isa_pkg::word_t reset_pc   = '0;
  localparam rv_isa_pkg::word_t inst_bytes = 4;  // PC step

endpackage

`default_nettype wire

//--- logic/rv_decoder.sv
// Decodes the kept RV32I subset only; any other encoding comes out as a bubble
`default_nettype none

module rv_decoder (
  input  rv_isa_pkg::inst_t    inst,
  output logic                 reg_write,
  output logic                 mem_read,
  output logic                 mem_write,
  output logic                 alu_src_imm,
  output logic                 branch,
  output logic                 jal,
  output rv_pipe_pkg::alu_op_t alu_op,
  output rv_isa_pkg::word_t    imm
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  rv_isa_pkg::word_t   imm_i;
  rv_isa_pkg::word_t   imm_s;
  rv_isa_pkg::word_t   imm_b;
  rv_isa_pkg::word_t   imm_j;

  assign opcode = rv_isa_pkg::opcode_t'(inst[6:0]);
  assign funct3 = inst[rv_isa_pkg::funct3_lsb +: $bits(rv_isa_pkg::funct3_t)];
  assign funct7 = inst[rv_isa_pkg::funct7_lsb +: $bits(rv_isa_pkg::funct7_t)];

  // Sign-extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb
  begin
    reg_write   = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    alu_src_imm = 1'b0;
    branch      = 1'b0;
    jal         = 1'b0;
    alu_op      = rv_pipe_pkg::alu_add;
    imm         = imm_i;
    case (opcode)
      rv_isa_pkg::op_r:
      begin
        reg_write = 1'b1;
        if (funct7 == rv_isa_pkg::f7_sub && funct3 == rv_isa_pkg::f3_add)
          alu_op = rv_pipe_pkg::alu_sub;
        else if (funct7 != rv_isa_pkg::f7_base)
          reg_write = 1'b0;
        else if (funct3 == rv_isa_pkg::f3_and)
          alu_op = rv_pipe_pkg::alu_and;
        else if (funct3 == rv_isa_pkg::f3_or)
          alu_op = rv_pipe_pkg::alu_or;
        else if (funct3 != rv_isa_pkg::f3_add)
          reg_write = 1'b0;  // Other R-type ops not kept
      end
      rv_isa_pkg::op_imm:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        case (funct3)
          rv_isa_pkg::f3_add: alu_op = rv_pipe_pkg::alu_add;
          rv_isa_pkg::f3_and: alu_op = rv_pipe_pkg::alu_and;
          rv_isa_pkg::f3_or:  alu_op = rv_pipe_pkg::alu_or;
          rv_isa_pkg::f3_xor: alu_op = rv_pipe_pkg::alu_xor;
          rv_isa_pkg::f3_sll:
          begin
            alu_op    = rv_pipe_pkg::alu_sll;
            reg_write = (funct7 == rv_isa_pkg::f7_base);
          end
          default:
          begin
            reg_write   = 1'b0;
            alu_src_imm = 1'b0;
          end
        endcase
      end
      rv_isa_pkg::op_load:
      begin
        reg_write   = (funct3 == rv_isa_pkg::f3_word);
        mem_read    = (funct3 == rv_isa_pkg::f3_word);
        alu_src_imm = 1'b1;  // Address is rs1 plus offset
      end
      rv_isa_pkg::op_store:
      begin
        mem_write   = (funct3 == rv_isa_pkg::f3_word);
        alu_src_imm = 1'b1;
        imm         = imm_s;
      end
      rv_isa_pkg::op_branch:
      begin
        branch = (funct3 == rv_isa_pkg::f3_beq) || (funct3 == rv_isa_pkg::f3_bne);
        alu_op = rv_pipe_pkg::alu_sub;  // Compare through zero flag
        imm    = imm_b;
      end
      rv_isa_pkg::op_jal:
      begin
        reg_write = 1'b1;
        jal       = 1'b1;
        imm       = imm_j;
      end
      default:
      begin
        imm = imm_i;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
// Two combinational read ports; a write is seen by reads only after the clock edge
`default_nettype none

module rv_regfile (
  input  logic                 clk,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    rd_data,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);

  // x1 to x31, x0 has no storage
  rv_isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk)
  begin
    if (we && rd != '0)
      regs[rd] <= rd_data;
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- logic/rv_alu.sv
// Integer ALU with zero flag only; shift uses the low five bits of b
`default_nettype none

module rv_alu (
  input  rv_isa_pkg::word_t    a,
  input  rv_isa_pkg::word_t    b,
  input  rv_pipe_pkg::alu_op_t alu_op,
  output rv_isa_pkg::word_t    result,
  output logic                 zero
);

  always_comb
  begin
    case (alu_op)
      rv_pipe_pkg::alu_add: result = a + b;
      rv_pipe_pkg::alu_sub: result = a - b;   // Also used for BEQ/BNE
      rv_pipe_pkg::alu_and: result = a & b;
      rv_pipe_pkg::alu_or:  result = a | b;
      rv_pipe_pkg::alu_xor: result = a ^ b;
      rv_pipe_pkg::alu_sll: result = a << b[4:0];
      default:              result = '0;
    endcase
  end

  // Equal operands under SUB
  assign zero = (result == '0);

endmodule

`default_nettype wire

//--- logic/rv_hazard_unit.sv
// Forwarding into decode from EX, MEM and WB plus a one-cycle load-use stall; no JALR support
`default_nettype none

module rv_hazard_unit (
  input  rv_isa_pkg::reg_idx_t  id_rs1,
  input  rv_isa_pkg::reg_idx_t  id_rs2,
  input  rv_isa_pkg::reg_idx_t  ex_rd,
  input  rv_isa_pkg::reg_idx_t  mem_rd,
  input  rv_isa_pkg::reg_idx_t  wb_rd,
  input  logic                  ex_reg_write,
  input  logic                  ex_mem_read,
  input  logic                  mem_reg_write,
  input  logic                  mem_read,
  input  logic                  wb_reg_write,
  output rv_pipe_pkg::fwd_sel_t fwd_rs1,
  output rv_pipe_pkg::fwd_sel_t fwd_rs2,
  output logic                  stall
);

  // Youngest in-flight producer of src wins
  function automatic rv_pipe_pkg::fwd_sel_t pick_source(input rv_isa_pkg::reg_idx_t src);
    rv_pipe_pkg::fwd_sel_t sel;
    sel = rv_pipe_pkg::fwd_rf;
    if (src == '0)
      sel = rv_pipe_pkg::fwd_rf;                      // x0 never forwarded
    else if (ex_reg_write && !ex_mem_read && ex_rd == src)
      sel = rv_pipe_pkg::fwd_ex_alu;
    else if (mem_reg_write && mem_read && mem_rd == src)
      sel = rv_pipe_pkg::fwd_mem_rdata;
    else if (mem_reg_write && !mem_read && mem_rd == src)
      sel = rv_pipe_pkg::fwd_mem_alu;
    else if (wb_reg_write && wb_rd == src)
      sel = rv_pipe_pkg::fwd_wb;                      // Same-cycle RF write
    return sel;
  endfunction

  always_comb
  begin
    fwd_rs1 = pick_source(id_rs1);
    fwd_rs2 = pick_source(id_rs2);
  end

  // ##################################################
  // Load-use detection

  // Load data is not ready until the memory stage, so hold decode one cycle
  always_comb
  begin
    stall = 1'b0;
    if (ex_mem_read && ex_rd != '0)
      stall = (ex_rd == id_rs1) || (ex_rd == id_rs2);
  end

endmodule

`default_nettype wire

//--- logic/rv_core.sv
// Five-stage RV32I subset core; memories must answer in the same cycle, no back-pressure
`default_nettype none

module rv_core (
  input  logic              clk,
  input  logic              reset,
  output rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::inst_t inst,
  output logic              mem_read,
  output logic              mem_write,
  output rv_isa_pkg::word_t mem_addr,
  output rv_isa_pkg::word_t mem_wdata,
  input  rv_isa_pkg::word_t mem_rdata
);

  // Decode stage
  rv_isa_pkg::inst_t     id_inst;
  rv_isa_pkg::word_t     id_pc, id_rs1_data, id_rs2_data, rf_rs1_data, rf_rs2_data;
  rv_isa_pkg::reg_idx_t  id_rs1, id_rs2;
  rv_pipe_pkg::fwd_sel_t fwd_rs1, fwd_rs2;
  logic                  stall;
  logic                  dec_reg_write, dec_mem_read, dec_mem_write;
  logic                  dec_alu_src_imm, dec_branch, dec_jal;
  rv_pipe_pkg::alu_op_t  dec_alu_op;
  rv_isa_pkg::word_t     dec_imm;

  // Execute stage
  rv_isa_pkg::word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm, alu_b, ex_alu_result, ex_target;
  rv_isa_pkg::reg_idx_t  ex_rd;
  rv_isa_pkg::funct3_t   ex_funct3;
  rv_pipe_pkg::alu_op_t  ex_alu_op;
  logic                  ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
  logic                  ex_branch, ex_jal, alu_zero, branch_taken, redirect;

  // Memory and write-back stages
  rv_isa_pkg::word_t     mem_pc, mem_alu_result, wb_pc, wb_alu_result, wb_rdata, rd_data;
  rv_isa_pkg::reg_idx_t  mem_rd, wb_rd;
  logic                  mem_reg_write, mem_jal, wb_reg_write, wb_mem_read, wb_jal;

  // ##################################################
  // Program counter
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      pc <= rv_pipe_pkg::reset_pc;
    else if (redirect)
      pc <= ex_target;  // Wins over a stall
    else if (!stall)
      pc <= pc + rv_pipe_pkg::inst_bytes;
  end

  // ##################################################
  // IF/ID register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      id_inst <= '0;  // Opcode zero decodes as a bubble
    else if (redirect)
      id_inst <= '0;
    else if (!stall)
      id_inst <= inst;
  end

  always_ff @(posedge clk)
  begin
    if (!stall)
      id_pc <= pc;
  end

  assign id_rs1 = id_inst[rv_isa_pkg::rs1_lsb +: rv_isa_pkg::reg_idx_w];
  assign id_rs2 = id_inst[rv_isa_pkg::rs2_lsb +: rv_isa_pkg::reg_idx_w];

  rv_decoder i_decoder (
    .inst        (id_inst),
    .reg_write   (dec_reg_write),
    .mem_read    (dec_mem_read),
    .mem_write   (dec_mem_write),
    .alu_src_imm (dec_alu_src_imm),
    .branch      (dec_branch),
    .jal         (dec_jal),
    .alu_op      (dec_alu_op),
    .imm         (dec_imm)
  );

  rv_regfile i_regfile (
    .clk      (clk),
    .we       (wb_reg_write),
    .rs1      (id_rs1),
    .rs2      (id_rs2),
    .rd       (wb_rd),
    .rd_data  (rd_data),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data)
  );

  rv_hazard_unit i_hazard_unit (
    .id_rs1        (id_rs1),
    .id_rs2        (id_rs2),
    .ex_rd         (ex_rd),
    .mem_rd        (mem_rd),
    .wb_rd         (wb_rd),
    .ex_reg_write  (ex_reg_write),
    .ex_mem_read   (ex_mem_read),
    .mem_reg_write (mem_reg_write),
    .mem_read      (mem_read),
    .wb_reg_write  (wb_reg_write),
    .fwd_rs1       (fwd_rs1),
    .fwd_rs2       (fwd_rs2),
    .stall         (stall)
  );

  // Operand value for one forwarding code
  function automatic rv_isa_pkg::word_t fwd_value(input rv_pipe_pkg::fwd_sel_t sel,
                                                  input rv_isa_pkg::word_t rf_value);
    case (sel)
      rv_pipe_pkg::fwd_ex_alu:    return ex_alu_result;
      rv_pipe_pkg::fwd_mem_rdata: return mem_rdata;
      rv_pipe_pkg::fwd_mem_alu:   return mem_alu_result;
      rv_pipe_pkg::fwd_wb:        return rd_data;
      default:                    return rf_value;
    endcase
  endfunction

  always_comb
  begin
    id_rs1_data = fwd_value(fwd_rs1, rf_rs1_data);
    id_rs2_data = fwd_value(fwd_rs2, rf_rs2_data);
  end

  // ##################################################
  // ID/EX register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      {ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_jal} <= '0;
    else if (redirect || stall)
      {ex_reg_write, ex_mem_read, ex_mem_write, ex_branch, ex_jal} <= '0;  // Bubble
    else
    begin
      ex_reg_write <= dec_reg_write;
      ex_mem_read  <= dec_mem_read;
      ex_mem_write <= dec_mem_write;
      ex_branch    <= dec_branch;
      ex_jal       <= dec_jal;
    end
  end

  always_ff @(posedge clk)
  begin
    ex_pc          <= id_pc;
    ex_rs1_data    <= id_rs1_data;
    ex_rs2_data    <= id_rs2_data;
    ex_imm         <= dec_imm;
    ex_rd          <= id_inst[rv_isa_pkg::rd_lsb +: rv_isa_pkg::reg_idx_w];
    ex_funct3      <= id_inst[rv_isa_pkg::funct3_lsb +: $bits(rv_isa_pkg::funct3_t)];
    ex_alu_op      <= dec_alu_op;
    ex_alu_src_imm <= dec_alu_src_imm;
  end

  assign alu_b = ex_alu_src_imm ? ex_imm : ex_rs2_data;

  rv_alu i_alu (
    .a      (ex_rs1_data),
    .b      (alu_b),
    .alu_op (ex_alu_op),
    .result (ex_alu_result),
    .zero   (alu_zero)
  );

  // One adder serves branch and JAL targets
  assign ex_target    = ex_pc + ex_imm;
  assign branch_taken = ex_branch && ((ex_funct3 == rv_isa_pkg::f3_beq && alu_zero) ||
                                      (ex_funct3 == rv_isa_pkg::f3_bne && !alu_zero));
  assign redirect     = branch_taken || ex_jal;  // Squashes decode and fetch

  // ##################################################
  // EX/MEM register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      {mem_reg_write, mem_read, mem_write, mem_jal} <= '0;
    else
      {mem_reg_write, mem_read, mem_write, mem_jal} <=
        {ex_reg_write, ex_mem_read, ex_mem_write, ex_jal};
  end

  always_ff @(posedge clk)
  begin
    mem_pc         <= ex_pc;
    mem_alu_result <= ex_alu_result;
    mem_wdata      <= ex_rs2_data;  // Store data
    mem_rd         <= ex_rd;
  end

  assign mem_addr = mem_alu_result;

  // ##################################################
  // MEM/WB register
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      {wb_reg_write, wb_mem_read, wb_jal} <= '0;
    else
      {wb_reg_write, wb_mem_read, wb_jal} <= {mem_reg_write, mem_read, mem_jal};
  end

  always_ff @(posedge clk)
  begin
    wb_pc         <= mem_pc;
    wb_alu_result <= mem_alu_result;
    wb_rdata      <= mem_rdata;
    wb_rd         <= mem_rd;
  end

  // Link value, load data or ALU result
  always_comb
  begin
    if (wb_jal)
      rd_data = wb_pc + rv_pipe_pkg::inst_bytes;
    else if (wb_mem_read)
      rd_data = wb_rdata;
    else
      rd_data = wb_alu_result;
  end

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
// Free-running clock of period 10; reset is released on a rising edge after 8 cycles
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    reset <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;  // Released on an edge
  end

endmodule

`default_nettype wire

//--- tests/tb_core_chk.sv
// Bound into every rv_core; relies on the core's internal names stall, redirect and ex_* bits
`default_nettype none

module tb_core_chk (
  input logic              clk,
  input logic              reset,
  input logic              mem_read,
  input logic              mem_write,
  input rv_isa_pkg::word_t pc,
  input logic              stall,
  input logic              redirect,
  input logic              branch_taken,
  input logic              ex_ctrl_any
);

  // ##################################################
  // Memory port
  no_read_write: assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
    else $error("mem_read and mem_write high in the same cycle");

  quiet_in_reset: assert property (@(posedge clk) reset |-> !mem_write)
    else $error("mem_write high while reset is asserted");

  // ##################################################
  // Hazard and squash
  stall_holds_pc: assert property (@(posedge clk) disable iff (reset)
    (stall && !redirect) |=> $stable(pc))
    else $error("pc moved during a load-use stall");

  branch_clears_ex: assert property (@(posedge clk) disable iff (reset)
    branch_taken |=> !ex_ctrl_any)  // Squashed slot is a bubble
    else $error("execute stage not cleared after a taken branch");

endmodule

bind rv_core tb_core_chk chk_i (
  .clk          (clk),
  .reset        (reset),
  .mem_read     (mem_read),
  .mem_write    (mem_write),
  .pc           (pc),
  .stall        (stall),
  .redirect     (redirect),
  .branch_taken (branch_taken),
  .ex_ctrl_any  (ex_reg_write | ex_mem_read | ex_mem_write | ex_branch | ex_jal)
);

`default_nettype wire

//--- tests/tb_core.sv
// Programs start at address zero, halt on a JAL to itself and only touch x1 to x7 after setup
`default_nettype none

module tb_core;

  localparam int imem_words = 256;
  localparam int dmem_words = 64;

  logic              clk, reset, mem_read, mem_write, released;
  rv_isa_pkg::word_t pc, mem_addr, mem_wdata, mem_rdata, exp_a, exp_d, halt_pc;
  rv_isa_pkg::inst_t inst;
  rv_isa_pkg::inst_t imem [imem_words];
  rv_isa_pkg::word_t dmem [dmem_words];
  rv_isa_pkg::word_t exp_addr [$];
  rv_isa_pkg::word_t exp_data [$];
  rv_isa_pkg::word_t exp_load [$];
  logic [31:0]       lfsr_state = 32'd92;  // Seed
  int                prog_len, store_slot, cycles, cycle_limit;

  tb_clock clock_i (.clk(clk), .reset(reset));

  rv_core dut_i (
    .clk (clk), .reset (reset), .pc (pc), .inst (inst),
    .mem_read (mem_read), .mem_write (mem_write),
    .mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
  );

  assign inst      = imem[pc[9:2]];  // Same-cycle fetch
  assign mem_rdata = dmem[mem_addr[7:2]];

  // ##################################################
  // Random numbers and encoders
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic rv_isa_pkg::reg_idx_t rand_reg();
    logic [31:0] v;
    v = rand_bits(3);
    return (v == 0) ? 5'd7 : 5'(v);  // x1 to x7
  endfunction

  function automatic rv_isa_pkg::word_t fill_word(input int idx);
    return (idx * 32'h9E37_79B1) ^ 32'h5A5A_0000 ^ (idx << 24);
  endfunction

  function automatic logic [11:0] store_off();
    store_slot++;
    return 12'((store_slot % 32) * 4);  // Words 0 to 31
  endfunction

  function automatic rv_isa_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_r};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2);
    return {imm[11:5], rs2, 5'd0, rv_isa_pkg::f3_word, imm[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic rv_isa_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  function automatic void put(input rv_isa_pkg::inst_t i);
    imem[prog_len] = i;
    prog_len++;
  endfunction

  // ##################################################
  // Program builder
  function automatic void build_program();
    logic [4:0] a, b, c;
    logic [2:0] f3;
    for (int k = 1; k < 8; k++)
      put(enc_i(12'(rand_bits(12)), 5'd0, rv_isa_pkg::f3_add, 5'(k), rv_isa_pkg::op_imm));
    repeat (3)
    begin
      for (int k = 0; k < 9; k++)
      begin
        a = rand_reg();
        b = rand_reg();
        c = rand_reg();
        case (k)
          0: put(enc_r(rv_isa_pkg::f7_base, c, b, rv_isa_pkg::f3_add, a));
          1: put(enc_r(rv_isa_pkg::f7_sub, c, b, rv_isa_pkg::f3_add, a));
          2: put(enc_r(rv_isa_pkg::f7_base, c, b, rv_isa_pkg::f3_and, a));
          3: put(enc_r(rv_isa_pkg::f7_base, c, b, rv_isa_pkg::f3_or, a));
          4: put(enc_i(12'(rand_bits(12)), b, rv_isa_pkg::f3_add, a, rv_isa_pkg::op_imm));
          5: put(enc_i(12'(rand_bits(12)), b, rv_isa_pkg::f3_and, a, rv_isa_pkg::op_imm));
          6: put(enc_i(12'(rand_bits(12)), b, rv_isa_pkg::f3_or, a, rv_isa_pkg::op_imm));
          7: put(enc_i(12'(rand_bits(12)), b, rv_isa_pkg::f3_xor, a, rv_isa_pkg::op_imm));
          default: put(enc_i(12'(rand_bits(5)), b, rv_isa_pkg::f3_sll, a, rv_isa_pkg::op_imm));
        endcase
        put(enc_s(store_off(), a));  // Needs the result at once
      end
    end
    repeat (4)
    begin
      a = rand_reg();
      b = rand_reg();
      c = rand_reg();
      put(enc_i(12'(rand_bits(6) << 2), 5'd0, rv_isa_pkg::f3_word, a, rv_isa_pkg::op_load));
      put(enc_r(rv_isa_pkg::f7_base, c, a, rv_isa_pkg::f3_add, b));  // Load-use
      put(enc_s(store_off(), b));
      put(enc_i(12'(rand_bits(6) << 2), 5'd0, rv_isa_pkg::f3_word, a, rv_isa_pkg::op_load));
      put(enc_s(store_off(), a));
    end
    for (int k = 0; k < 8; k++)
    begin
      a  = rand_reg();
      b  = k[1] ? a : rand_reg();  // Equal operands half the time
      f3 = k[0] ? rv_isa_pkg::f3_bne : rv_isa_pkg::f3_beq;
      put(enc_b(13'd12, b, a, f3));
      put(enc_s(store_off(), a));  // Skipped when taken
      put(enc_s(store_off(), b));
    end
    put(enc_j(21'd12, 5'd5));
    put(enc_s(store_off(), 5'd1));
    put(enc_s(store_off(), 5'd2));
    put(enc_s(store_off(), 5'd5));  // Link value
    put(enc_i(12'd123, 5'd0, rv_isa_pkg::f3_add, 5'd0, rv_isa_pkg::op_imm));
    put(enc_r(rv_isa_pkg::f7_base, 5'd2, 5'd1, rv_isa_pkg::f3_add, 5'd0));
    put(enc_s(store_off(), 5'd0));
    halt_pc = 32'(prog_len * 4);
    put(enc_j(21'd0, 5'd0));
  endfunction

  // ##################################################
  // Reference model
  function automatic void ref_run();
    rv_isa_pkg::word_t x [32];
    rv_isa_pkg::word_t mem [dmem_words];
    rv_isa_pkg::word_t rpc, nxt, a, b, res, addr, imm_i, imm_s, imm_b, imm_j;
    rv_isa_pkg::inst_t i;
    logic              wr;
    for (int k = 0; k < 32; k++)
      x[k] = '0;
    for (int k = 0; k < dmem_words; k++)
      mem[k] = fill_word(k);
    rpc = '0;
    for (int step = 0; step < 4000; step++)
    begin
      i     = imem[rpc[9:2]];
      a     = x[i[19:15]];
      b     = x[i[24:20]];
      imm_i = {{20{i[31]}}, i[31:20]};
      imm_s = {{20{i[31]}}, i[31:25], i[11:7]};
      imm_b = {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      imm_j = {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      nxt   = rpc + 4;
      wr    = 1'b0;
      res   = '0;
      if (i[6:0] == rv_isa_pkg::op_jal && imm_j == 0)
        break;  // Halt
      case (i[6:0])
        rv_isa_pkg::op_r:
        begin
          wr = 1'b1;
          if (i[30])
            res = a - b;
          else if (i[14:12] == 3'b111)
            res = a & b;
          else if (i[14:12] == 3'b110)
            res = a | b;
          else
            res = a + b;
        end
        rv_isa_pkg::op_imm:
        begin
          wr = 1'b1;
          case (i[14:12])
            3'b111:  res = a & imm_i;
            3'b110:  res = a | imm_i;
            3'b100:  res = a ^ imm_i;
            3'b001:  res = a << imm_i[4:0];
            default: res = a + imm_i;
          endcase
        end
        rv_isa_pkg::op_load:
        begin
          wr   = 1'b1;
          addr = a + imm_i;
          res  = mem[addr[7:2]];
          exp_load.push_back(addr);
        end
        rv_isa_pkg::op_store:
        begin
          addr = a + imm_s;
          mem[addr[7:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        rv_isa_pkg::op_branch:
          if ((i[14:12] == 3'b000) == (a == b))
            nxt = rpc + imm_b;  // BEQ equal or BNE unequal
        default:
        begin
          wr  = 1'b1;  // JAL
          res = rpc + 4;
          nxt = rpc + imm_j;
        end
      endcase
      if (wr && i[11:7] != 0)
        x[i[11:7]] = res;
      rpc = nxt;
    end
  endfunction

  // ##################################################
  // Checks
  task automatic fail_value(input string msg, input rv_isa_pkg::word_t got,
                            input rv_isa_pkg::word_t exp);
    $display("FAILED at time %0t: %s got %h expected %h", $time, msg, got, exp);
    $display("ERRORS FOUND");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped");
  endtask

  task automatic check_store_addr(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp);
    if (got !== exp)
      fail_value("store address", got, exp);
  endtask

  task automatic check_store_data(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp);
    if (got !== exp)
      fail_value("store data", got, exp);
  endtask

  task automatic check_load_addr(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp);
    if (got !== exp)
      fail_value("load address", got, exp);
  endtask

  task automatic check_pc(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp);
    if (got !== exp)
      fail_value("pc around reset", got, exp);
  endtask

  // Compares every load and store and keeps the data memory
  always @(posedge clk)
  begin
    cycles++;
    if (cycles > cycle_limit)
      fail_plain("Timeout: the program did not reach its halt instruction in time");
    if (reset || !released)
    begin
      check_pc(pc, rv_pipe_pkg::reset_pc);
      if (mem_write !== 1'b0 || mem_read !== 1'b0)
        fail_plain("mem_write or mem_read was not low around reset");
      if (!reset)
        released = 1'b1;
    end
    else if (mem_read)
    begin
      if (exp_load.size() == 0)
        fail_plain("The core made a load that the program does not contain");
      exp_a = exp_load.pop_front();
      check_load_addr(mem_addr, exp_a);
    end
    else if (mem_write)
    begin
      if (exp_addr.size() == 0)
        fail_plain("The core made a store that the program does not contain");
      exp_a = exp_addr.pop_front();
      exp_d = exp_data.pop_front();
      check_store_addr(mem_addr, exp_a);
      check_store_data(mem_wdata, exp_d);
      dmem[mem_addr[7:2]] <= mem_wdata;
    end
  end

  initial
  begin
    released   = 1'b0;
    cycles     = 0;
    prog_len   = 0;
    store_slot = 0;
    for (int k = 0; k < imem_words; k++)
      imem[k] = '0;
    for (int k = 0; k < dmem_words; k++)
      dmem[k] = fill_word(k);
    build_program();
    ref_run();
    cycle_limit = 8 + 3 * prog_len + 40;
    wait (reset === 1'b0);
    while (pc !== halt_pc)
      @(posedge clk);
    repeat (8) @(posedge clk);  // Drain the pipeline
    if (exp_addr.size() != 0 || exp_load.size() != 0)
    begin
      $display("The core missed %0d expected stores and %0d expected loads",
               exp_addr.size(), exp_load.size());
      $display("ERRORS FOUND");
      $fatal(1, "missing memory accesses");
    end
    else
    begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- sim.f
logic/rv_isa_pkg.sv
logic/rv_pipe_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_hazard_unit.sv
logic/rv_core.sv
tests/tb_clock.sv
tests/tb_core_chk.sv
tests/tb_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - logic/rv_isa_pkg.sv
  - logic/rv_pipe_pkg.sv
  - logic/rv_decoder.sv
  - logic/rv_regfile.sv
  - logic/rv_alu.sv
  - logic/rv_hazard_unit.sv
  - logic/rv_core.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_core_chk.sv
      - tests/tb_core.sv
